// File: adc_sample_capture.sv
`timescale 1ns/10ps
`default_nettype none

module adc_sample_capture import husky_pkg::*; (
   input  wire                 clk_usb_buf,
   input  wire                 rst_n_i,
   input  wire [ADC_PINS-1:0]  adc_dp_i,
   input  wire [ADC_PINS-1:0]  adc_dn_i,
   input  wire                 arm_i,
   input  byte_t               sample_count_i,
   output logic                capturing_o,
   output logic                samp_wr_o,
   output sample_t             samp_data_o
);

   typedef enum logic {
      IDLE,
      CAPTURE
   } cap_state_e;

   cap_state_e state_q;
   byte_t      remain_q;   // Samples still to write
   sample_t    adc_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         remain_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (arm_i && sample_count_i != '0) begin
                  state_q  <= CAPTURE;
                  remain_q <= sample_count_i;
               end
            end
            CAPTURE: begin
               remain_q <= remain_q - 8'd1;
               if (remain_q == 8'd1)
                  state_q <= IDLE;   // Last sample goes out this clock
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Single-rate pin sample, no reset on the data path
   always_ff @(posedge clk_usb_buf) begin
      adc_q <= {adc_dp_i, adc_dn_i};
   end

   assign capturing_o = (state_q == CAPTURE);
   assign samp_wr_o   = (state_q == CAPTURE);
   assign samp_data_o = adc_q;

endmodule

`default_nettype wire

// File: capture_regs.sv
`timescale 1ns/10ps
`default_nettype none

module capture_regs import husky_pkg::*; #(
   parameter int pFIFO_DEPTH = 32,
   parameter int pSEG_WORDS  = 8
) (
   input  wire                                 clk_usb_buf,
   input  wire                                 rst_n_i,
   input  reg_addr_e                           reg_addr_i,
   input  byte_t                               reg_wdata_i,
   input  wire                                 reg_write_i,
   input  wire                                 reg_read_i,
   output byte_t                               reg_rdata_o,
   input  wire                                 capturing_i,
   output logic                                arm_o,
   output byte_t                               sample_count_o,
   output logic                                armed_o,
   input  sample_t                             fifo_rdata_i,
   input  wire [$clog2(pFIFO_DEPTH+1)-1:0]     fifo_count_i,
   input  wire                                 fifo_empty_i,
   input  wire                                 overflow_i,
   output logic                                fifo_pop_o,
   output logic                                ovf_clear_o,
   output logic                                segment_avail_o
);

   localparam int CNT_W = $clog2(pFIFO_DEPTH + 1);

   logic  capturing_q;   // For the end-of-capture edge
   logic  hi_sel_q;      // Next FIFO read returns the high byte
   logic  arm_wr;
   logic  fifo_rd;
   byte_t status;
   byte_t fifo_byte;

   assign arm_wr = reg_write_i && reg_addr_i == REG_ARM && reg_wdata_i[0]
                   && !armed_o && sample_count_o != '0;
   assign fifo_rd = reg_read_i && reg_addr_i == REG_FIFO_DATA && !fifo_empty_i;

   assign ovf_clear_o = reg_write_i && reg_addr_i == REG_STATUS && reg_wdata_i[1];

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sample_count_o  <= 8'd1;
         arm_o           <= 1'b0;
         armed_o         <= 1'b0;
         capturing_q     <= 1'b0;
         hi_sel_q        <= 1'b0;
         fifo_pop_o      <= 1'b0;
         segment_avail_o <= 1'b0;
      end else begin
         if (reg_write_i && reg_addr_i == REG_SAMPLES)
            sample_count_o <= reg_wdata_i;
         arm_o       <= arm_wr;
         capturing_q <= capturing_i;
         if (arm_wr)
            armed_o <= 1'b1;
         else if (capturing_q && !capturing_i)
            armed_o <= 1'b0;   // Capture finished
         // Pop once both halves of the head sample are out
         fifo_pop_o <= fifo_rd & hi_sel_q;
         if (fifo_rd)
            hi_sel_q <= ~hi_sel_q;
         segment_avail_o <= (fifo_count_i >= CNT_W'(pSEG_WORDS));
      end
   end

   assign status = {4'b0000, fifo_empty_i, segment_avail_o, overflow_i, armed_o};

   always_comb begin
      if (fifo_empty_i)
         fifo_byte = '0;
      else if (hi_sel_q)
         fifo_byte = {{(2*BUS_BITS-ADC_BITS){1'b0}}, fifo_rdata_i[ADC_BITS-1:BUS_BITS]};
      else
         fifo_byte = fifo_rdata_i[BUS_BITS-1:0];
   end

   always_comb begin
      case (reg_addr_i)
         REG_ARM:       reg_rdata_o = {7'b0000000, armed_o};
         REG_SAMPLES:   reg_rdata_o = sample_count_o;
         REG_STATUS:    reg_rdata_o = status;
         REG_FIFO_DATA: reg_rdata_o = fifo_byte;
         default:       reg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: flist.f
husky_pkg.sv
usb_reg_bus.sv
adc_sample_capture.sv
sample_fifo.sv
capture_regs.sv
status_leds.sv
husky_capture_top.sv
tb_checker.sv
tb_husky_capture.sv

// File: husky_capture_top.sv
`timescale 1ns/10ps
`default_nettype none

module husky_capture_top import husky_pkg::*; #(
   parameter int pFIFO_DEPTH    = 32,
   parameter int pSEG_WORDS     = 8,
   parameter int pHEARTBEAT_BIT = 22
) (
   input  wire                 clk_usb_buf,
   input  wire                 rst_n_i,
   input  byte_t               usb_addr_i,
   input  byte_t               usb_data_i,
   input  wire                 usb_rdn_i,
   input  wire                 usb_wrn_i,
   input  wire                 usb_cen_i,
   input  wire                 usb_alen_i,
   output byte_t               usb_data_o,
   output logic                usb_data_oe_o,
   input  wire [ADC_PINS-1:0]  adc_dp_i,
   input  wire [ADC_PINS-1:0]  adc_dn_i,
   input  wire                 pll_status_i,
   output logic                stream_segment_available_o,
   output logic                led_clk1fail_o,
   output logic                led_armed_o,
   output logic                led_cap_o
);

   localparam int CNT_W = $clog2(pFIFO_DEPTH + 1);

   reg_addr_e         reg_addr;
   byte_t             reg_wdata;
   byte_t             reg_rdata;
   logic              reg_write;
   logic              reg_read;
   logic              arm;
   byte_t             sample_count;
   logic              armed;
   logic              capturing;
   logic              samp_wr;
   sample_t           samp_data;
   sample_t           fifo_rdata;
   logic [CNT_W-1:0]  fifo_count;
   logic              fifo_empty;
   logic              overflow;
   logic              fifo_pop;
   logic              ovf_clear;

   usb_reg_bus u_usb_reg_bus (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .reg_rdata_i   (reg_rdata),
      .reg_addr_o    (reg_addr),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o)
   );

   adc_sample_capture u_adc_sample_capture (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .adc_dp_i       (adc_dp_i),
      .adc_dn_i       (adc_dn_i),
      .arm_i          (arm),
      .sample_count_i (sample_count),
      .capturing_o    (capturing),
      .samp_wr_o      (samp_wr),
      .samp_data_o    (samp_data)
   );

   sample_fifo #(
      .pFIFO_DEPTH (pFIFO_DEPTH)
   ) u_sample_fifo (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .wr_i        (samp_wr),
      .wdata_i     (samp_data),
      .pop_i       (fifo_pop),
      .ovf_clear_i (ovf_clear),
      .rdata_o     (fifo_rdata),
      .count_o     (fifo_count),
      .empty_o     (fifo_empty),
      .overflow_o  (overflow)
   );

   capture_regs #(
      .pFIFO_DEPTH (pFIFO_DEPTH),
      .pSEG_WORDS  (pSEG_WORDS)
   ) u_capture_regs (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .reg_read_i      (reg_read),
      .reg_rdata_o     (reg_rdata),
      .capturing_i     (capturing),
      .arm_o           (arm),
      .sample_count_o  (sample_count),
      .armed_o         (armed),
      .fifo_rdata_i    (fifo_rdata),
      .fifo_count_i    (fifo_count),
      .fifo_empty_i    (fifo_empty),
      .overflow_i      (overflow),
      .fifo_pop_o      (fifo_pop),
      .ovf_clear_o     (ovf_clear),
      .segment_avail_o (stream_segment_available_o)
   );

   status_leds #(
      .pHEARTBEAT_BIT (pHEARTBEAT_BIT)
   ) u_status_leds (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .overflow_i     (overflow),
      .pll_status_i   (pll_status_i),
      .armed_i        (armed),
      .capturing_i    (capturing),
      .led_clk1fail_o (led_clk1fail_o),
      .led_armed_o    (led_armed_o),
      .led_cap_o      (led_cap_o)
   );

endmodule

`default_nettype wire

// File: husky_pkg.sv
`default_nettype none

package husky_pkg;

   // Datapath widths
   localparam int ADC_BITS = 12;
   localparam int ADC_PINS = 6;   // Per polarity, {dp, dn} forms a sample
   localparam int BUS_BITS = 8;

   typedef logic [ADC_BITS-1:0] sample_t;
   typedef logic [BUS_BITS-1:0] byte_t;

   // Register map on the USB bus
   typedef enum logic [7:0] {
      REG_ARM       = 8'h10,   // Bit 0 starts a capture
      REG_SAMPLES   = 8'h11,   // Samples per capture
      REG_STATUS    = 8'h12,   // Armed, overflow, segment, empty
      REG_FIFO_DATA = 8'h13    // Low byte then high byte of each sample
   } reg_addr_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f \
   --top-module tb_husky_capture -o sim_husky_capture
./obj_dir/sim_husky_capture > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi

// File: sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo import husky_pkg::*; #(
   parameter int pFIFO_DEPTH = 32
) (
   input  wire                                 clk_usb_buf,
   input  wire                                 rst_n_i,
   input  wire                                 wr_i,
   input  sample_t                             wdata_i,
   input  wire                                 pop_i,
   input  wire                                 ovf_clear_i,
   output sample_t                             rdata_o,
   output logic [$clog2(pFIFO_DEPTH+1)-1:0]    count_o,
   output logic                                empty_o,
   output logic                                overflow_o
);

   localparam int AW = $clog2(pFIFO_DEPTH);

   sample_t        mem [pFIFO_DEPTH];
   logic [AW-1:0]  wr_ptr_q;
   logic [AW-1:0]  rd_ptr_q;
   logic           full;
   logic           do_wr;
   logic           do_rd;

   assign full    = (count_o == pFIFO_DEPTH);
   assign empty_o = (count_o == '0);
   assign do_wr   = wr_i & ~full;   // Dropped when full
   assign do_rd   = pop_i & ~empty_o;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_o    <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr)
            wr_ptr_q <= (wr_ptr_q == AW'(pFIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= (rd_ptr_q == AW'(pFIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (do_wr && !do_rd)
            count_o <= count_o + 1'b1;
         else if (do_rd && !do_wr)
            count_o <= count_o - 1'b1;
         // Sticky until cleared; a new drop wins over the clear
         if (wr_i && full)
            overflow_o <= 1'b1;
         else if (ovf_clear_i)
            overflow_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (do_wr)
         mem[wr_ptr_q] <= wdata_i;
   end

   assign rdata_o = mem[rd_ptr_q];   // Fall-through head word

endmodule

`default_nettype wire

// File: status_leds.sv
`timescale 1ns/10ps
`default_nettype none

module status_leds #(
   parameter int pHEARTBEAT_BIT = 22
) (
   input  wire   clk_usb_buf,
   input  wire   rst_n_i,
   input  wire   overflow_i,
   input  wire   pll_status_i,
   input  wire   armed_i,
   input  wire   capturing_i,
   output logic  led_clk1fail_o,
   output logic  led_armed_o,
   output logic  led_cap_o
);

   logic [pHEARTBEAT_BIT:0] heartbeat_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i)
         heartbeat_q <= '0;
      else
         heartbeat_q <= heartbeat_q + 1'b1;
   end

   // Fast flash on internal error, else show PLL lock loss
   assign led_clk1fail_o = overflow_i ? heartbeat_q[pHEARTBEAT_BIT] : ~pll_status_i;
   assign led_armed_o    = armed_i;
   assign led_cap_o      = capturing_i;

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker import husky_pkg::*; (
   input  wire             clk_usb_buf,
   input  wire [8*16-1:0]  name_i,
   input  byte_t           exp_i,
   input  wire             chk_data_i,    // Exact compare of read data
   input  wire             chk_pins_i,    // LEDs, segment pin and data enable
   input  wire             chk_lo_i,      // Low byte of a sample
   input  wire             chk_hi_i,      // High byte, closes the sample
   input  wire             timeout_i,
   input  wire             test_end_i,
   input  wire             totals_i,
   input  byte_t           usb_data_i,
   input  wire             usb_data_oe_i,
   input  wire             seg_avail_i,
   input  wire             led_clk1fail_i,
   input  wire             led_armed_i,
   input  wire             led_cap_i,
   output int              failed_o
);

   int      step_errs = 0;
   int      tests_run = 0;
   int      fails = 0;
   byte_t   lo_q = '0;
   sample_t prev_q = '0;
   sample_t samp;
   logic    have_prev = 1'b0;   // No sample seen yet in this test
   byte_t   pins;

   // Data enable sits low whenever no read strobe is active
   assign pins     = {3'b000, usb_data_oe_i, seg_avail_i, led_cap_i, led_armed_i,
                      led_clk1fail_i};
   assign failed_o = fails;

   task automatic compare_byte(input byte_t exp, input byte_t act);
      if (act !== exp) begin
         $display("mismatch %0s: expected 0x%02h, actual 0x%02h", name_i, exp, act);
         step_errs++;
      end
   endtask

   // Outputs are sampled half a clock after the TB strobes
   always @(negedge clk_usb_buf) begin
      if ((chk_data_i || chk_lo_i || chk_hi_i) && usb_data_oe_i !== 1'b1) begin
         $display("%0s: data output enable is not high during a read", name_i);
         step_errs++;
      end
      if (chk_data_i)
         compare_byte(exp_i, usb_data_i);
      if (chk_pins_i)
         compare_byte(exp_i, pins);
      if (chk_lo_i)
         lo_q = usb_data_i;
      if (chk_hi_i) begin
         samp = {usb_data_i[3:0], lo_q};
         if (usb_data_i > 8'h0F) begin
            $display("mismatch %0s: expected high byte at most 0x0f, actual 0x%02h",
                     name_i, usb_data_i);
            step_errs++;
         end else if (have_prev && samp !== prev_q + 12'd1) begin
            $display("mismatch %0s: expected 0x%03h, actual 0x%03h",
                     name_i, prev_q + 12'd1, samp);
            step_errs++;
         end
         prev_q    = samp;
         have_prev = 1'b1;
      end
      if (timeout_i) begin
         $display("%0s: timed out waiting for the DUT to respond", name_i);
         step_errs++;
      end
      if (test_end_i) begin
         tests_run++;
         if (step_errs == 0) begin
            $display("test %0s passed", name_i);
         end else begin
            $display("test %0s failed with %0d errors", name_i, step_errs);
            fails++;
         end
         step_errs = 0;
         have_prev = 1'b0;   // Each test starts a fresh sample run
      end
      if (totals_i)
         $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - fails, fails);
   end

endmodule

`default_nettype wire

// File: tb_husky_capture.sv
`timescale 1ns/10ps
`default_nettype none

module tb_husky_capture import husky_pkg::*; ();

   localparam int   DEPTH     = 32;
   localparam int   SEG_WORDS = 8;
   localparam int   HB_BIT    = 3;
   localparam int   MAX_STEPS = 40;
   localparam logic PLL_LOCKED = 1'b1;
   localparam byte_t PLL_LED  = {7'b0000000, ~PLL_LOCKED};   // Fail LED with no overflow

   localparam int SEL_NONE  = 0;
   localparam int SEL_EXACT = 1;
   localparam int SEL_LO    = 2;
   localparam int SEL_HI    = 3;

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_READ,
      OP_PINS,
      OP_WAIT_IDLE,
      OP_WAIT_BLINK,
      OP_DRAIN       // Value field holds the sample count
   } op_e;

   logic                clk_usb_buf = 1'b0;
   logic                rst_n_i;
   byte_t               usb_addr_i;
   byte_t               usb_data_i;
   logic                usb_rdn_i;
   logic                usb_wrn_i;
   logic                usb_cen_i;
   logic                usb_alen_i;
   logic [ADC_PINS-1:0] adc_dp_i = '0;
   logic [ADC_PINS-1:0] adc_dn_i = '0;
   logic                pll_status_i;
   byte_t               usb_data_o;
   logic                usb_data_oe_o;
   logic                seg_avail;
   logic                led_clk1fail;
   logic                led_armed;
   logic                led_cap;

   logic [8*16-1:0]     cur_name;
   byte_t               chk_exp;
   logic                chk_data;
   logic                chk_pins;
   logic                chk_lo;
   logic                chk_hi;
   logic                timeout_strb;
   logic                test_end;
   logic                totals;
   int                  fail_count;

   logic [8*16-1:0]     step_name [MAX_STEPS];
   op_e                 step_op   [MAX_STEPS];
   byte_t               step_addr [MAX_STEPS];
   byte_t               step_val  [MAX_STEPS];
   byte_t               step_exp  [MAX_STEPS];
   int                  n_steps = 0;
   logic [31:0]         rnd_state = 32'h9dd0;

   always #20 clk_usb_buf = ~clk_usb_buf;

   // Free-running 12-bit ADC ramp
   always @(posedge clk_usb_buf)
      {adc_dp_i, adc_dn_i} <= {adc_dp_i, adc_dn_i} + 12'd1;

   husky_capture_top #(
      .pFIFO_DEPTH    (DEPTH),
      .pSEG_WORDS     (SEG_WORDS),
      .pHEARTBEAT_BIT (HB_BIT)
   ) i_dut (
      .clk_usb_buf                (clk_usb_buf),
      .rst_n_i                    (rst_n_i),
      .usb_addr_i                 (usb_addr_i),
      .usb_data_i                 (usb_data_i),
      .usb_rdn_i                  (usb_rdn_i),
      .usb_wrn_i                  (usb_wrn_i),
      .usb_cen_i                  (usb_cen_i),
      .usb_alen_i                 (usb_alen_i),
      .usb_data_o                 (usb_data_o),
      .usb_data_oe_o              (usb_data_oe_o),
      .adc_dp_i                   (adc_dp_i),
      .adc_dn_i                   (adc_dn_i),
      .pll_status_i               (pll_status_i),
      .stream_segment_available_o (seg_avail),
      .led_clk1fail_o             (led_clk1fail),
      .led_armed_o                (led_armed),
      .led_cap_o                  (led_cap)
   );

   tb_checker u_checker (
      .clk_usb_buf    (clk_usb_buf),
      .name_i         (cur_name),
      .exp_i          (chk_exp),
      .chk_data_i     (chk_data),
      .chk_pins_i     (chk_pins),
      .chk_lo_i       (chk_lo),
      .chk_hi_i       (chk_hi),
      .timeout_i      (timeout_strb),
      .test_end_i     (test_end),
      .totals_i       (totals),
      .usb_data_i     (usb_data_o),
      .usb_data_oe_i  (usb_data_oe_o),
      .seg_avail_i    (seg_avail),
      .led_clk1fail_i (led_clk1fail),
      .led_armed_i    (led_armed),
      .led_cap_i      (led_cap),
      .failed_o       (fail_count)
   );

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic pick_count(input int lo, input int span, output byte_t val);
      rnd_state = next_random(rnd_state);
      val = byte_t'(lo + int'(rnd_state[23:16]) % span);   // Upper bits, better spread
   endtask

   task automatic add_step(input logic [8*16-1:0] name, input op_e op, input byte_t addr,
                           input byte_t val, input byte_t exp);
      step_name[n_steps] = name;
      step_op[n_steps]   = op;
      step_addr[n_steps] = addr;
      step_val[n_steps]  = val;
      step_exp[n_steps]  = exp;
      n_steps++;
   endtask

   task automatic build_table();
      byte_t n_a;
      byte_t n_b;
      byte_t n_cap;
      byte_t n_seg;
      byte_t n_ovf;
      pick_count(1, DEPTH, n_a);
      pick_count(1, DEPTH, n_b);
      pick_count(1, DEPTH, n_cap);
      pick_count(SEG_WORDS, DEPTH - SEG_WORDS + 1, n_seg);
      pick_count(DEPTH + 1, 16, n_ovf);
      add_step("reset_leds", OP_PINS, 8'h00, 8'h00, PLL_LED);
      add_step("reset_status", OP_READ, REG_STATUS, 8'h00, 8'h08);
      add_step("samples_wr_a", OP_WRITE, REG_SAMPLES, n_a, 8'h00);
      add_step("samples_rd_a", OP_READ, REG_SAMPLES, 8'h00, n_a);
      add_step("samples_wr_b", OP_WRITE, REG_SAMPLES, n_b, 8'h00);
      add_step("samples_rd_b", OP_READ, REG_SAMPLES, 8'h00, n_b);
      add_step("cap_count", OP_WRITE, REG_SAMPLES, n_cap, 8'h00);
      add_step("cap_arm", OP_WRITE, REG_ARM, 8'h01, 8'h00);
      add_step("cap_wait", OP_WAIT_IDLE, 8'h00, 8'h00, 8'h00);
      add_step("cap_drain", OP_DRAIN, 8'h00, n_cap, 8'h00);
      add_step("cap_status", OP_READ, REG_STATUS, 8'h00, 8'h08);
      add_step("cap_empty_read", OP_READ, REG_FIFO_DATA, 8'h00, 8'h00);
      add_step("seg_count", OP_WRITE, REG_SAMPLES, n_seg, 8'h00);
      add_step("seg_arm", OP_WRITE, REG_ARM, 8'h01, 8'h00);
      add_step("seg_wait", OP_WAIT_IDLE, 8'h00, 8'h00, 8'h00);
      add_step("seg_high", OP_PINS, 8'h00, 8'h00, 8'h08 | PLL_LED);
      add_step("seg_drain_part", OP_DRAIN, 8'h00, byte_t'(n_seg - SEG_WORDS + 1), 8'h00);
      add_step("seg_low", OP_PINS, 8'h00, 8'h00, PLL_LED);
      add_step("seg_drain_rest", OP_DRAIN, 8'h00, byte_t'(SEG_WORDS - 1), 8'h00);
      add_step("seg_status", OP_READ, REG_STATUS, 8'h00, 8'h08);
      add_step("ovf_count", OP_WRITE, REG_SAMPLES, n_ovf, 8'h00);
      add_step("ovf_arm", OP_WRITE, REG_ARM, 8'h01, 8'h00);
      // Capture of more than DEPTH samples is still running here
      add_step("ovf_leds", OP_PINS, 8'h00, 8'h00, 8'h06 | PLL_LED);
      add_step("ovf_wait", OP_WAIT_IDLE, 8'h00, 8'h00, 8'h00);
      add_step("ovf_status", OP_READ, REG_STATUS, 8'h00, 8'h06);   // Overflow, segment
      add_step("ovf_blink", OP_WAIT_BLINK, 8'h00, 8'h00, 8'h00);
      add_step("ovf_drain", OP_DRAIN, 8'h00, byte_t'(DEPTH), 8'h00);
      add_step("ovf_empty", OP_READ, REG_STATUS, 8'h00, 8'h0A);
      add_step("ovf_empty_read", OP_READ, REG_FIFO_DATA, 8'h00, 8'h00);
      add_step("ovf_clear", OP_WRITE, REG_STATUS, 8'h02, 8'h00);
      add_step("ovf_cleared", OP_READ, REG_STATUS, 8'h00, 8'h08);
      add_step("ovf_led", OP_PINS, 8'h00, 8'h00, PLL_LED);
   endtask

   task automatic set_address(input byte_t addr);
      @(posedge clk_usb_buf);
      usb_addr_i <= addr;
      usb_alen_i <= 1'b0;
      @(posedge clk_usb_buf);
      usb_alen_i <= 1'b1;
   endtask

   task automatic write_reg(input byte_t addr, input byte_t val);
      set_address(addr);
      usb_data_i <= val;
      usb_cen_i  <= 1'b0;
      usb_wrn_i  <= 1'b0;
      repeat (3) @(posedge clk_usb_buf);
      usb_wrn_i <= 1'b1;
      usb_cen_i <= 1'b1;
      repeat (2) @(posedge clk_usb_buf);
   endtask

   // Strobe low for 5 clocks, data checked in the 4th
   task automatic read_reg(input byte_t addr, input int sel, input byte_t exp);
      set_address(addr);
      usb_cen_i <= 1'b0;
      usb_rdn_i <= 1'b0;
      repeat (3) @(posedge clk_usb_buf);
      chk_exp  <= exp;
      chk_data <= (sel == SEL_EXACT);
      chk_lo   <= (sel == SEL_LO);
      chk_hi   <= (sel == SEL_HI);
      @(posedge clk_usb_buf);
      chk_data <= 1'b0;
      chk_lo   <= 1'b0;
      chk_hi   <= 1'b0;
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b1;
      usb_cen_i <= 1'b1;
      @(posedge clk_usb_buf);
   endtask

   task automatic flag_timeout();
      @(posedge clk_usb_buf);
      timeout_strb <= 1'b1;
      @(posedge clk_usb_buf);
      timeout_strb <= 1'b0;
   endtask

   task automatic end_test();
      @(posedge clk_usb_buf);
      test_end <= 1'b1;
      @(posedge clk_usb_buf);
      test_end <= 1'b0;
   endtask

   task automatic request_totals();
      @(posedge clk_usb_buf);
      totals <= 1'b1;
      @(posedge clk_usb_buf);
      totals <= 1'b0;
   endtask

   task automatic check_pins(input byte_t exp);
      @(posedge clk_usb_buf);
      chk_exp  <= exp;
      chk_pins <= 1'b1;
      @(posedge clk_usb_buf);
      chk_pins <= 1'b0;
   endtask

   task automatic wait_idle();
      int   polls;
      logic idle;
      polls = 0;
      idle  = 1'b0;
      while (!idle && polls < 40) begin
         read_reg(REG_STATUS, SEL_NONE, 8'h00);
         idle = (usb_data_o[0] == 1'b0);   // Armed bit
         polls++;
      end
      if (!idle)
         flag_timeout();
   endtask

   task automatic wait_blink();
      logic start;
      int   cycles;
      @(negedge clk_usb_buf);
      start  = led_clk1fail;
      cycles = 0;
      while (led_clk1fail == start && cycles < 64) begin
         @(negedge clk_usb_buf);
         cycles++;
      end
      if (led_clk1fail == start)
         flag_timeout();
   endtask

   task automatic drain_samples(input int count);
      for (int i = 0; i < count; i++) begin
         read_reg(REG_FIFO_DATA, SEL_LO, 8'h00);
         read_reg(REG_FIFO_DATA, SEL_HI, 8'h00);
      end
   endtask

   initial begin
      rst_n_i      = 1'b0;
      usb_addr_i   = '0;
      usb_data_i   = '0;
      usb_rdn_i    = 1'b1;
      usb_wrn_i    = 1'b1;
      usb_cen_i    = 1'b1;
      usb_alen_i   = 1'b1;
      pll_status_i = PLL_LOCKED;
      cur_name     = '0;
      chk_exp      = '0;
      chk_data     = 1'b0;
      chk_pins     = 1'b0;
      chk_lo       = 1'b0;
      chk_hi       = 1'b0;
      timeout_strb = 1'b0;
      test_end     = 1'b0;
      totals       = 1'b0;
      build_table();
      repeat (5) @(posedge clk_usb_buf);
      rst_n_i <= 1'b1;
      repeat (2) @(posedge clk_usb_buf);
      for (int i = 0; i < n_steps; i++) begin
         cur_name <= step_name[i];
         case (step_op[i])
            OP_WRITE:      write_reg(step_addr[i], step_val[i]);
            OP_READ:       read_reg(step_addr[i], SEL_EXACT, step_exp[i]);
            OP_PINS:       check_pins(step_exp[i]);
            OP_WAIT_IDLE:  wait_idle();
            OP_WAIT_BLINK: wait_blink();
            OP_DRAIN:      drain_samples(int'(step_val[i]));
            default:       ;
         endcase
         end_test();
      end
      request_totals();
      @(posedge clk_usb_buf);
      if (fail_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: usb_reg_bus.sv
`timescale 1ns/10ps
`default_nettype none

module usb_reg_bus import husky_pkg::*; (
   input  wire        clk_usb_buf,
   input  wire        rst_n_i,
   input  byte_t      usb_addr_i,
   input  byte_t      usb_data_i,
   input  wire        usb_rdn_i,
   input  wire        usb_wrn_i,
   input  wire        usb_cen_i,
   input  wire        usb_alen_i,
   input  byte_t      reg_rdata_i,
   output reg_addr_e  reg_addr_o,
   output byte_t      reg_wdata_o,
   output logic       reg_write_o,
   output logic       reg_read_o,
   output byte_t      usb_data_o,
   output logic       usb_data_oe_o
);

   logic wr_act_q;   // Strobe samples, first register
   logic wr_act_qq;
   logic rd_act_q;
   logic rd_act_qq;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_addr_o    <= reg_addr_e'(8'h00);
         wr_act_q      <= 1'b0;
         wr_act_qq     <= 1'b0;
         rd_act_q      <= 1'b0;
         rd_act_qq     <= 1'b0;
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         usb_data_oe_o <= 1'b0;
      end else begin
         if (!usb_alen_i)
            reg_addr_o <= reg_addr_e'(usb_addr_i);   // Address phase
         wr_act_q      <= ~usb_wrn_i & ~usb_cen_i;
         wr_act_qq     <= wr_act_q;
         rd_act_q      <= ~usb_rdn_i & ~usb_cen_i;
         rd_act_qq     <= rd_act_q;
         reg_write_o   <= wr_act_q & ~wr_act_qq;   // One pulse per strobe
         reg_read_o    <= rd_act_q & ~rd_act_qq;
         usb_data_oe_o <= ~usb_rdn_i & ~usb_cen_i;
      end
   end

   // Write data taken with the pulse, read data held until the next read
   always_ff @(posedge clk_usb_buf) begin
      if (wr_act_q && !wr_act_qq)
         reg_wdata_o <= usb_data_i;
      if (reg_read_o)
         usb_data_o <= reg_rdata_i;
   end

endmodule

`default_nettype wire
